// ==== project.f ====
+incdir+bench
design/squeeze_pkg.sv
design/tap_if.sv
design/coeff_rom.sv
design/mac_unit.sv
design/layer_control.sv
design/output_stage.sv
design/squeeze_layer.sv
bench/tb_squeeze_layer.sv

// ==== Bender.yml ====
package:
  name: squeeze_layer

sources:
  - files:
      - design/squeeze_pkg.sv
      - design/tap_if.sv
      - design/coeff_rom.sv
      - design/mac_unit.sv
      - design/layer_control.sv
      - design/output_stage.sv
      - design/squeeze_layer.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/tb_squeeze_layer.sv

// ==== bench/squeeze_checks.svh ====
// Compare tasks and random source for the squeeze layer testbench
// Included inside the testbench module, relies on its abort_run task
// Every compare stops the run at the first mismatch
`ifndef SQUEEZE_CHECKS_SVH
`define SQUEEZE_CHECKS_SVH

	// LCG state, fixed seed so every run sees the same stimulus
	int unsigned lcg_state = 95967;

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// Upper bits only, low LCG bits cycle too fast
	function automatic int rand_below(input int n);
		return int'(lcg_next() >> 16) % n;
	endfunction

	// Activation in -4096..4095
	function automatic pixel_t rand_act();
		return pixel_t'(rand_below(8192) - 4096);
	endfunction

	// One output lane of one window
	task automatic check_pixel(input pixel_t got, input pixel_t exp, input int lane,
			input int window);
		if (got !== exp) begin
			$display("** Error @ %0t: window %0d lane %0d ofm %0d, expected %0d",
				$time, window, lane, got, exp);
			abort_run();
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string name);
		if (got !== exp) begin
			$display("** Error @ %0t: %s is %b, expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	// Sample counts and cycle distances
	task automatic check_count(input int got, input int exp, input string name);
		if (got != exp) begin
			$display("** Error @ %0t: %s is %0d, expected %0d", $time, name, got, exp);
			abort_run();
		end
	endtask

`endif

// ==== bench/tb_squeeze_layer.sv ====
// Testbench for the squeeze convolution layer
// Streams windows of activations into the DUT, models each window from the
// package weight and bias rules and compares every sample in order
// Covers reset, strobe timing, back-to-back windows, paused input,
// saturation and the finish handshake
`default_nettype none

module tb_squeeze_layer
	import squeeze_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_MAC    = 8;
	localparam int CHIN       = 16;
	localparam int KERNEL_DIM = 1;
	localparam int NUM_PIXELS = 16;
	localparam int TAPS       = KERNEL_DIM * KERNEL_DIM * CHIN;
	localparam int TIMEOUT    = 20 * TAPS;
	localparam int PIX_MAX    = 32767;

	logic   clk;
	logic   reset;
	logic   layer_en;
	pixel_t ifm;
	logic   mem_ack;
	logic   sample;
	logic   finish;
	pixel_t ofm [0:NUM_MAC-1];

	// Activations of the window being sent
	pixel_t win_acts [0:TAPS-1];
	// Expected and observed ofm, NUM_MAC entries per window
	pixel_t exp_q [$];
	pixel_t got_q [$];
	// finish and cycle number seen with each sample
	logic   fin_q [$];
	int     sample_cyc [$];
	int     cyc = 0;
	int     n_samples = 0;
	int     n_checked = 0;
	int     win_sent = 0;
	int     last_tap_cyc = 0;

	task automatic abort_run();
		$display("FAIL: see errors above");
		$fatal(1, "stopped at first error");
	endtask

	`include "squeeze_checks.svh"

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	squeeze_layer #(
		.NUM_MAC    (NUM_MAC),
		.CHIN       (CHIN),
		.KERNEL_DIM (KERNEL_DIM),
		.NUM_PIXELS (NUM_PIXELS)
	) i_dut (
		.clk      (clk),
		.reset    (reset),
		.layer_en (layer_en),
		.ifm      (ifm),
		.mem_ack  (mem_ack),
		.sample   (sample),
		.finish   (finish),
		.ofm      (ofm)
	);

	// Monitor sees values from before each edge
	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (sample) begin
			for (int f = 0; f < NUM_MAC; f++) begin
				got_q.push_back(ofm[f]);
			end
			fin_q.push_back(finish);
			sample_cyc.push_back(cyc);
			n_samples <= n_samples + 1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Reference model and stimulus
	//////////////////////////////////////////////////////////////////////

	// Sum of products, bias, rescale, ReLU, clip
	task automatic model_window();
		longint sum;
		for (int f = 0; f < NUM_MAC; f++) begin
			sum = 0;
			for (int t = 0; t < TAPS; t++) begin
				sum += longint'(win_acts[t]) * longint'(coeff_weight(f, t));
			end
			sum = (sum + longint'(coeff_bias(f))) >>> FRAC_BITS;
			if (sum < 0) begin
				sum = 0;
			end else if (sum > PIX_MAX) begin
				sum = PIX_MAX;
			end
			exp_q.push_back(pixel_t'(sum));
		end
	endtask

	task automatic fill_random();
		for (int t = 0; t < TAPS; t++) begin
			win_acts[t] = rand_act();
		end
	endtask

	// gap_pct is the chance of a pause before each tap after the first
	task automatic send_window(input int gap_pct);
		int gap;
		for (int t = 0; t < TAPS; t++) begin
			if (t > 0 && rand_below(100) < gap_pct) begin
				gap = 1 + rand_below(4);
				// Junk on ifm while paused
				repeat (gap) begin
					@(posedge clk);
					layer_en <= 1'b0;
					ifm      <= rand_act();
				end
			end
			@(posedge clk);
			layer_en <= 1'b1;
			ifm      <= win_acts[t];
			last_tap_cyc = cyc;
		end
		model_window();
		win_sent++;
	endtask

	task automatic stop_stream();
		@(posedge clk);
		layer_en <= 1'b0;
	endtask

	task automatic wait_samples(input int n);
		int waited;
		waited = 0;
		while (n_samples < n && waited < TIMEOUT) begin
			@(posedge clk);
			waited++;
		end
		if (n_samples < n) begin
			$display("Timeout after %0d cycles waiting for sample %0d, only %0d seen",
				waited, n, n_samples);
			abort_run();
		end
	endtask

	// Compare every window not yet checked, in arrival order
	task automatic check_results();
		for (int w = n_checked; w < n_samples; w++) begin
			for (int f = 0; f < NUM_MAC; f++) begin
				check_pixel(got_q[w*NUM_MAC+f], exp_q[w*NUM_MAC+f], f, w);
			end
		end
		n_checked = n_samples;
	endtask

	// Quiet period catches duplicate strobes
	task automatic drain_and_check(input string name);
		stop_stream();
		wait_samples(win_sent);
		repeat (TAPS) @(posedge clk);
		check_count(n_samples, win_sent, name);
		check_results();
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic test_reset_state();
		$display("Test: reset state");
		@(posedge clk);
		check_flag(sample, 1'b0, "sample after reset");
		check_flag(finish, 1'b0, "finish after reset");
		for (int f = 0; f < NUM_MAC; f++) begin
			check_pixel(ofm[f], '0, f, -1);
		end
	endtask

	task automatic test_single_window();
		$display("Test: single window, constant activation");
		for (int t = 0; t < TAPS; t++) begin
			win_acts[t] = pixel_t'(16384);
		end
		send_window(0);
		drain_and_check("samples for one window");
		// Strobe visible three cycles after the tap, seen on the fourth edge
		check_count(sample_cyc[0] - last_tap_cyc, 4, "edges from final tap to sample");
	endtask

	task automatic test_back_to_back();
		$display("Test: back-to-back windows");
		for (int w = 0; w < 8; w++) begin
			fill_random();
			send_window(0);
		end
		drain_and_check("samples after back-to-back windows");
	endtask

	task automatic test_paused_input();
		$display("Test: paused input");
		for (int w = 0; w < 4; w++) begin
			fill_random();
			send_window(30);
		end
		drain_and_check("samples after paused windows");
	endtask

	task automatic test_saturation();
		weight_t w;
		int      first;
		$display("Test: saturation and ReLU");
		// Lane 0 follows the activation signs, lane 3 mostly runs against them
		for (int t = 0; t < TAPS; t++) begin
			w = coeff_weight(0, t);
			if (w > 0) begin
				win_acts[t] = pixel_t'(PIX_MAX);
			end else if (w < 0) begin
				win_acts[t] = pixel_t'(-PIX_MAX);
			end else begin
				win_acts[t] = '0;
			end
		end
		first = win_sent;
		send_window(0);
		drain_and_check("samples for saturation window");
		check_pixel(got_q[first*NUM_MAC], pixel_t'(PIX_MAX), 0, first);
		check_pixel(got_q[first*NUM_MAC+3], '0, 3, first);
	endtask

	task automatic test_layer_end();
		int waited;
		$display("Test: layer end and finish handshake");
		while (win_sent < NUM_PIXELS) begin
			fill_random();
			send_window(0);
		end
		// layer_en stays high past the last window
		repeat (2 * TAPS) begin
			@(posedge clk);
			ifm <= rand_act();
		end
		drain_and_check("samples at layer end");
		for (int i = 0; i < NUM_PIXELS; i++) begin
			check_flag(fin_q[i], (i == NUM_PIXELS - 1), "finish alongside sample");
		end
		check_flag(finish, 1'b1, "finish before mem_ack");
		@(posedge clk);
		mem_ack <= 1'b1;
		@(posedge clk);
		mem_ack <= 1'b0;
		waited = 0;
		while (finish !== 1'b0 && waited < TIMEOUT) begin
			@(posedge clk);
			waited++;
		end
		if (finish !== 1'b0) begin
			$display("Timeout: finish still high %0d cycles after mem_ack", waited);
			abort_run();
		end
		// Nothing may come back after release
		layer_en <= 1'b1;
		repeat (TAPS) begin
			@(posedge clk);
			check_flag(finish, 1'b0, "finish after release");
		end
		drain_and_check("samples after release");
	endtask

	initial begin
		reset    = 1'b1;
		layer_en = 1'b0;
		ifm      = '0;
		mem_ack  = 1'b0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		test_reset_state();
		test_single_window();
		test_back_to_back();
		test_paused_input();
		test_saturation();
		test_layer_end();
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

// ==== design/squeeze_layer.sv ====
// Top level of the squeeze convolution layer
// Streams one activation per cycle under layer_en, presents NUM_MAC results
// with a one-cycle sample strobe, and reports finish until mem_ack
// Only instances and the wiring between them live here
`default_nettype none

module squeeze_layer
	import squeeze_pkg::*;
#(
	parameter int NUM_MAC    = 8,
	parameter int CHIN       = 16,
	parameter int KERNEL_DIM = 1,
	parameter int NUM_PIXELS = 16
) (
	input  logic   clk,
	input  logic   reset,
	input  logic   layer_en,
	input  pixel_t ifm,
	input  logic   mem_ack,
	output logic   sample,
	output logic   finish,
	output pixel_t ofm [0:NUM_MAC-1]
);

	// Window length in activations
	localparam int TAPS = KERNEL_DIM * KERNEL_DIM * CHIN;

	weight_t weights [0:NUM_MAC-1];
	acc_t    biases  [0:NUM_MAC-1];
	acc_t    sums    [0:NUM_MAC-1];

	tap_if #(.TAPS(TAPS)) taps ();

	//////////////////////////////////////////////////////////////////////
	// Control and coefficients
	//////////////////////////////////////////////////////////////////////

	layer_control #(
		.CHIN       (CHIN),
		.KERNEL_DIM (KERNEL_DIM),
		.NUM_PIXELS (NUM_PIXELS)
	) u_control (
		.clk      (clk),
		.reset    (reset),
		.layer_en (layer_en),
		.ifm      (ifm),
		.mem_ack  (mem_ack),
		.sample   (sample),
		.finish   (finish),
		.taps     (taps.ctrl)
	);

	coeff_rom #(
		.NUM_MAC (NUM_MAC),
		.TAPS    (TAPS)
	) u_rom (
		.clk     (clk),
		.taps    (taps.data),
		.weights (weights),
		.biases  (biases)
	);

	//////////////////////////////////////////////////////////////////////
	// MAC bank and output
	//////////////////////////////////////////////////////////////////////

	for (genvar f = 0; f < NUM_MAC; f++) begin : g_mac
		mac_unit u_mac (
			.clk    (clk),
			.reset  (reset),
			.taps   (taps.data),
			.weight (weights[f]),
			.acc    (sums[f])
		);
	end

	output_stage #(
		.NUM_MAC (NUM_MAC)
	) u_out (
		.clk    (clk),
		.reset  (reset),
		.taps   (taps.data),
		.acc    (sums),
		.biases (biases),
		.ofm    (ofm)
	);

endmodule

`default_nettype wire

// ==== design/output_stage.sv ====
// Output stage of the squeeze layer
// Adds the lane bias, rescales from Q4.28 back to Q2.14, applies ReLU
// and clips to the positive pixel range, then registers ofm on capture
// ofm holds until the next capture
`default_nettype none

module output_stage
	import squeeze_pkg::*;
#(
	parameter int NUM_MAC = 8
) (
	input  logic   clk,
	input  logic   reset,
	tap_if.data    taps,
	input  acc_t   acc    [0:NUM_MAC-1],
	input  acc_t   biases [0:NUM_MAC-1],
	output pixel_t ofm    [0:NUM_MAC-1]
);

	localparam int SCALED_W = ACC_WIDTH + 1 - FRAC_BITS;
	localparam int PIX_MAX  = 2 ** (WIDTH - 1) - 1;

	for (genvar f = 0; f < NUM_MAC; f++) begin : g_lane
		logic signed [ACC_WIDTH:0]  biased;
		logic signed [SCALED_W-1:0] scaled;
		pixel_t                     clipped;

		// One guard bit so the bias add cannot wrap
		assign biased = acc[f] + biases[f];
		assign scaled = SCALED_W'(biased >>> FRAC_BITS);

		// ReLU then saturate
		always_comb begin
			if (scaled < 0) begin
				clipped = '0;
			end else if (scaled > SCALED_W'(PIX_MAX)) begin
				clipped = pixel_t'(PIX_MAX);
			end else begin
				clipped = pixel_t'(scaled);
			end
		end

		always_ff @(posedge clk) begin
			if (reset) begin
				ofm[f] <= '0;
			end else if (taps.capture) begin
				ofm[f] <= clipped;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/layer_control.sv ====
// Sequencer for the squeeze layer
// Counts taps per window and windows per layer, registers the activation
// and drives the tap stream, then delays the flags into MAC enables,
// capture and the sample strobe
// Holds finish from the last sample until mem_ack is seen
`default_nettype none

module layer_control
	import squeeze_pkg::*;
#(
	parameter int CHIN       = 16,
	parameter int KERNEL_DIM = 1,
	parameter int NUM_PIXELS = 16
) (
	input  logic   clk,
	input  logic   reset,
	input  logic   layer_en,
	input  pixel_t ifm,
	input  logic   mem_ack,
	output logic   sample,
	output logic   finish,
	tap_if.ctrl    taps
);

	localparam int TAPS   = KERNEL_DIM * KERNEL_DIM * CHIN;
	localparam int ADDR_W = tap_addr_w(TAPS);
	localparam int WIN_W  = $clog2(NUM_PIXELS + 1);

	layer_state_e      state;
	logic [ADDR_W-1:0] tap_cnt;
	logic [WIN_W-1:0]  win_cnt;
	logic              accept;
	logic              tap_last;
	logic              win_last;
	logic              end_q;
	logic              last_q;
	logic              last_cap;

	//////////////////////////////////////////////////////////////////////
	// Tap acceptance and counters
	//////////////////////////////////////////////////////////////////////

	// Input only taken while running
	assign accept   = layer_en && (state == RUN);
	assign tap_last = (tap_cnt == ADDR_W'(TAPS - 1));
	assign win_last = (win_cnt == WIN_W'(NUM_PIXELS - 1));

	// Counter doubles as the ROM address
	assign taps.tap_addr = tap_cnt;

	always_ff @(posedge clk) begin
		if (reset) begin
			tap_cnt <= '0;
			win_cnt <= '0;
		end else if (accept) begin
			if (tap_last) begin
				tap_cnt <= '0;
				win_cnt <= win_cnt + 1'b1;
			end else begin
				tap_cnt <= tap_cnt + 1'b1;
			end
		end
	end

	// Activation follows the address by one register
	always_ff @(posedge clk) begin
		if (accept) begin
			taps.pixel_q <= ifm;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Flag pipeline
	//////////////////////////////////////////////////////////////////////

	// Stage 1, aligned with pixel_q and the ROM output
	always_ff @(posedge clk) begin
		if (reset) begin
			taps.acc_valid <= 1'b0;
			taps.acc_first <= 1'b0;
			end_q          <= 1'b0;
			last_q         <= 1'b0;
		end else begin
			taps.acc_valid <= accept;
			taps.acc_first <= accept && (tap_cnt == '0);
			end_q          <= accept && tap_last;
			last_q         <= accept && tap_last && win_last;
		end
	end

	// Stage 2 capture, stage 3 sample
	always_ff @(posedge clk) begin
		if (reset) begin
			taps.capture <= 1'b0;
			last_cap     <= 1'b0;
			sample       <= 1'b0;
		end else begin
			taps.capture <= end_q;
			last_cap     <= last_q;
			sample       <= taps.capture;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Layer state
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= RUN;
		end else begin
			case (state)
				RUN:      if (accept && tap_last && win_last) state <= DRAIN;
				// Final window still in the pipeline
				DRAIN:    if (taps.capture && last_cap) state <= DONE;
				DONE:     if (mem_ack) state <= RELEASED;
				RELEASED: state <= RELEASED;
				default:  state <= RUN;
			endcase
		end
	end

	// Raised together with the last sample
	assign finish = (state == DONE);

	a_tap_range: assert property (
		@(posedge clk) disable iff (reset) int'(tap_cnt) < TAPS
	) else $error("layer_control: tap counter out of range");

	a_no_late_sample: assert property (
		@(posedge clk) disable iff (reset) (state == RELEASED) |=> !$rose(sample)
	) else $error("layer_control: sample after release");

endmodule

`default_nettype wire

// ==== design/mac_unit.sv ====
// One multiply-accumulate lane of the squeeze layer
// Multiplies the registered activation by this lane's weight
// The first tap of a window loads the product, later taps add to it
// Holds the sum while acc_valid is low
`default_nettype none

module mac_unit
	import squeeze_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	tap_if.data     taps,
	input  weight_t weight,
	output acc_t    acc
);

	acc_t pix_ext;
	acc_t wgt_ext;
	acc_t product;

	// Sign extend both operands to accumulator width
	assign pix_ext = acc_t'(taps.pixel_q);
	assign wgt_ext = acc_t'(weight);

	// Q2.14 times Q2.14 gives Q4.28 in the accumulator
	assign product = pix_ext * wgt_ext;

	always_ff @(posedge clk) begin
		if (reset) begin
			acc <= '0;
		end else if (taps.acc_valid) begin
			// Load on first tap, no separate clear cycle
			if (taps.acc_first) begin
				acc <= product;
			end else begin
				acc <= acc + product;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/coeff_rom.sv ====
// Coefficient ROM for the MAC bank
// One synchronous read returns NUM_MAC weights for the current tap address
// The bias table is constant and goes straight to the output stage
// Contents are generated at elaboration from the package rules
`default_nettype none

module coeff_rom
	import squeeze_pkg::*;
#(
	parameter int NUM_MAC = 8,
	parameter int TAPS    = 16
) (
	input  logic    clk,
	tap_if.data     taps,
	output weight_t weights [0:NUM_MAC-1],
	output acc_t    biases  [0:NUM_MAC-1]
);

	//////////////////////////////////////////////////////////////////////
	// Table contents
	//////////////////////////////////////////////////////////////////////

	// Weight table indexed by tap then lane
	weight_t rom [0:TAPS-1][0:NUM_MAC-1];

	for (genvar t = 0; t < TAPS; t++) begin : g_tap
		for (genvar f = 0; f < NUM_MAC; f++) begin : g_lane
			assign rom[t][f] = coeff_weight(f, t);
		end
	end

	// Biases need no read port
	for (genvar f = 0; f < NUM_MAC; f++) begin : g_bias
		assign biases[f] = coeff_bias(f);
	end

	//////////////////////////////////////////////////////////////////////
	// Read port
	//////////////////////////////////////////////////////////////////////

	// Registered read, weights line up with pixel_q on the next cycle
	always_ff @(posedge clk) begin
		for (int f = 0; f < NUM_MAC; f++) begin
			weights[f] <= rom[taps.tap_addr][f];
		end
	end

	// Any weight the MACs consume came from a valid address
	a_addr_range: assert property (
		@(posedge clk) taps.acc_valid |-> int'($past(taps.tap_addr)) < TAPS
	) else $error("coeff_rom: tap address out of range");

endmodule

`default_nettype wire

// ==== design/tap_if.sv ====
// Tap-stream control from the layer sequencer to the datapath
// Address for the coefficient ROM, MAC enables, capture strobe and activation
// ctrl side is driven by layer_control, data side is read by ROM, MACs and output stage
`default_nettype none

interface tap_if
	import squeeze_pkg::*;
#(
	parameter int TAPS = 16
) ();

	localparam int ADDR_W = tap_addr_w(TAPS);

	// ROM address of the tap being accepted
	logic [ADDR_W-1:0] tap_addr;
	// MAC control, one cycle behind acceptance
	logic              acc_valid;
	logic              acc_first;
	// Window complete, output stage registers the sums
	logic              capture;
	// Activation registered alongside the address
	pixel_t            pixel_q;

	modport ctrl (output tap_addr, acc_valid, acc_first, capture, pixel_q);
	modport data (input tap_addr, acc_valid, acc_first, capture, pixel_q);

endinterface

`default_nettype wire

// ==== design/squeeze_pkg.sv ====
// Shared types and constants for the squeeze convolution layer
// Widths, the control state enum and the fixed weight and bias rules
// Imported by every design module and used by the testbench reference model
`default_nettype none

package squeeze_pkg;

	//////////////////////////////////////////////////////////////////////
	// Fixed-point format
	//////////////////////////////////////////////////////////////////////

	// Activations and weights are Q2.14
	localparam int WIDTH     = 16;
	localparam int ACC_WIDTH = 32;
	localparam int FRAC_BITS = 14;

	typedef logic signed [WIDTH-1:0]     pixel_t;
	typedef logic signed [WIDTH-1:0]     weight_t;
	typedef logic signed [ACC_WIDTH-1:0] acc_t;

	// Layer sequencing
	typedef enum logic [1:0] {
		RUN,
		DRAIN,
		DONE,
		RELEASED
	} layer_state_e;

	//////////////////////////////////////////////////////////////////////
	// Helpers and coefficient rules
	//////////////////////////////////////////////////////////////////////

	// Tap address width, at least one bit
	function automatic int tap_addr_w(input int taps);
		return (taps > 1) ? $clog2(taps) : 1;
	endfunction

	// Weight for lane f at tap t, range -15..15 scaled by 256
	function automatic weight_t coeff_weight(input int f, input int t);
		int raw;
		raw = ((f * 7 + t * 3) % 31) - 15;
		return weight_t'(raw * 256);
	endfunction

	// Per-lane bias in accumulator units
	function automatic acc_t coeff_bias(input int f);
		return acc_t'((f - 3) * 4096);
	endfunction

endpackage

`default_nettype wire
